// File: Bender.yml
package:
  name: l2Cache

sources:
  - verilog/l2CachePkg.sv
  - verilog/memLatencyTimer.sv
  - verilog/l2SetArray.sv
  - verilog/mainMemory.sv
  - verilog/l2CacheCtrl.sv
  - verilog/l2CacheTop.sv
  - target: test
    files:
      - verification/l2CacheTb.sv

// File: compile.f
verilog/l2CachePkg.sv
verilog/memLatencyTimer.sv
verilog/l2SetArray.sv
verilog/mainMemory.sv
verilog/l2CacheCtrl.sv
verilog/l2CacheTop.sv
verification/l2CacheTb.sv

// File: verification/l2CacheTb.sv
`timescale 1ns/10ps

module l2CacheTb;

    localparam int SET_BITS      = 3;                       // Same as DUT defaults
    localparam int MEM_LATENCY   = 4;
    localparam int MEM_WORD_BITS = 10;
    localparam int TAG_BITS      = 30 - SET_BITS;
    localparam int SETS          = 1 << SET_BITS;
    localparam int DEPTH         = 1 << MEM_WORD_BITS;
    localparam int WAIT_LIMIT    = 60;                      // Cycles before a wait gives up

    logic                clk = 1'b0;
    logic                rstN;
    logic                cpuReq;
    l2CachePkg::cpuReqT  cpuReqData;
    logic                cpuAck;
    l2CachePkg::cpuRespT cpuResp;

    // Reference state for cache and memory
    logic [31:0]         refMem   [DEPTH];
    logic [TAG_BITS-1:0] refTag   [2][SETS];
    logic [31:0]         refData  [2][SETS];
    logic                refValid [2][SETS];
    logic                refDirty [2][SETS];
    logic                refLru   [SETS];                   // Next way to evict

    l2CachePkg::cpuReqT  reqLog  [$];                       // Finished requests
    l2CachePkg::cpuRespT respLog [$];                       // Their DUT responses
    logic [31:0]         rngState = 32'h03f7_482e;
    int                  checkCount = 0;
    int                  errorCount = 0;

    l2CacheTop dut_i (
        .clk       (clk),
        .rstN      (rstN),
        .cpuReq    (cpuReq),
        .cpuReqData(cpuReqData),
        .cpuAck    (cpuAck),
        .cpuResp   (cpuResp)
    );

    always #50 clk = ~clk;                                  // 100 ns period

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);             // Xorshift32
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic l2CachePkg::cpuReqT makeReq(input l2CachePkg::memOpT op,
            input l2CachePkg::accessSizeT size, input logic [31:0] addr,
            input logic [31:0] wdata);
        return '{op: op, size: size, addr: addr, wdata: wdata};
    endfunction

    task automatic resetModel();
        for (int i = 0; i < DEPTH; i++) begin
            refMem[i] = 32'hA5A5_0000 ^ 32'(i);             // Initial memory rule
        end
        for (int s = 0; s < SETS; s++) begin
            refValid[0][s] = 1'b0;
            refValid[1][s] = 1'b0;
            refDirty[0][s] = 1'b0;
            refDirty[1][s] = 1'b0;
            refLru[s]      = 1'b0;
        end
    endtask

    // Expected response, updates the shadow cache and memory
    function automatic l2CachePkg::cpuRespT refAccess(input l2CachePkg::cpuReqT r);
        l2CachePkg::cpuRespT resp;
        logic [SET_BITS-1:0] set;
        logic [TAG_BITS-1:0] tag;
        logic [31:0]         word;
        logic [31:0]         vAddr;
        int                  way;
        int                  off;
        set  = r.addr[SET_BITS+1:2];
        tag  = r.addr[31:SET_BITS+2];
        off  = r.addr[1:0];
        resp = '0;
        way  = -1;
        for (int w = 0; w < 2; w++) begin
            if (refValid[w][set] && refTag[w][set] == tag) way = w;
        end
        if (way >= 0) begin
            resp.hit = 1'b1;
        end else begin
            way = refLru[set];                              // LRU victim
            if (refValid[way][set] && refDirty[way][set]) begin
                vAddr = {refTag[way][set], set, 2'b00};
                refMem[vAddr[MEM_WORD_BITS+1:2]] = refData[way][set];
                resp.wroteBack = 1'b1;
            end
            refTag[way][set]   = tag;
            refData[way][set]  = refMem[r.addr[MEM_WORD_BITS+1:2]];
            refValid[way][set] = 1'b1;
            refDirty[way][set] = 1'b0;
        end
        word = refData[way][set];
        if (r.op == l2CachePkg::opStore) begin
            case (r.size)
                l2CachePkg::sizeByte: word[8*off +: 8]  = r.wdata[7:0];
                l2CachePkg::sizeHalf: word[8*off +: 16] = r.wdata[15:0];
                default:              word              = r.wdata;
            endcase
            refData[way][set]  = word;
            refDirty[way][set] = 1'b1;
        end
        refLru[set] = (way == 0);                           // Other way is now oldest
        resp.rdata  = word;
        return resp;
    endfunction

    task automatic checkResp(input string name, input l2CachePkg::cpuRespT exp,
            input l2CachePkg::cpuRespT act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic abortOnTimeout(input string what);
        l2CachePkg::ctrlStateT st;
        st = dut_i.ctrl_i.state;
        $display("Timeout: %s did not happen within %0d cycles, controller in %s",
                 what, WAIT_LIMIT, st.name());
        $display("Errors found");
        $finish;
    endtask

    // Four-phase handshake, latency counted from the sampling edge
    task automatic issueRequest(input l2CachePkg::cpuReqT req,
            output l2CachePkg::cpuRespT resp, output int latency);
        int cycles;
        @(negedge clk);
        cpuReqData = req;
        cpuReq     = 1'b1;
        cycles     = 0;
        while (!cpuAck) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) abortOnTimeout("cpuAck rise");
        end
        resp    = cpuResp;                                  // Stable mid-cycle
        latency = cycles - 1;
        reqLog.push_back(req);
        respLog.push_back(resp);
        cpuReq = 1'b0;
        cycles = 0;
        while (cpuAck) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) abortOnTimeout("cpuAck fall");
        end
    endtask

    // Comparing process
    always @(posedge clk) begin
        while (reqLog.size() > 0) begin
            checkResp("cpuResp", refAccess(reqLog.pop_front()), respLog.pop_front());
        end
    end

    task automatic finishTest(input string name, input int errBefore);
        int cycles;
        cycles = 0;
        while (reqLog.size() > 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) abortOnTimeout("response comparison");
        end
        $display("Test %s finished with %0d errors", name, errorCount - errBefore);
    endtask

    initial begin
        l2CachePkg::cpuRespT    resp;
        l2CachePkg::accessSizeT sz;
        logic [31:0]            r;
        logic [1:0]             off;
        int                     lat;
        int                     errBefore;
        cpuReq     = 1'b0;
        cpuReqData = '0;
        rstN       = 1'b0;
        resetModel();
        repeat (16) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);

        errBefore = errorCount;
        checkBit("cpuAck", 1'b0, cpuAck);
        issueRequest(makeReq(l2CachePkg::opLoad, l2CachePkg::sizeWord, 32'h100, '0), resp, lat);
        finishTest("reset and cold miss", errBefore);

        errBefore = errorCount;
        issueRequest(makeReq(l2CachePkg::opLoad, l2CachePkg::sizeWord, 32'h100, '0), resp, lat);
        checkCount++;
        if (lat >= MEM_LATENCY + 3) begin
            errorCount++;
            $display("Load hit took %0d cycles, as long as a miss", lat);
        end
        finishTest("load hit", errBefore);

        errBefore = errorCount;                             // Miss then merges
        issueRequest(makeReq(l2CachePkg::opStore, l2CachePkg::sizeByte, 32'h209, 32'h5A), resp, lat);
        issueRequest(makeReq(l2CachePkg::opStore, l2CachePkg::sizeHalf, 32'h20A, 32'hBEEF), resp, lat);
        issueRequest(makeReq(l2CachePkg::opLoad, l2CachePkg::sizeWord, 32'h208, '0), resp, lat);
        issueRequest(makeReq(l2CachePkg::opStore, l2CachePkg::sizeWord, 32'h208, 32'h1234_5678),
                     resp, lat);
        issueRequest(makeReq(l2CachePkg::opLoad, l2CachePkg::sizeWord, 32'h208, '0), resp, lat);
        finishTest("sized stores", errBefore);

        errBefore = errorCount;                             // Three tags in set 5
        issueRequest(makeReq(l2CachePkg::opStore, l2CachePkg::sizeWord, 32'h014, 32'hCAFE_F00D),
                     resp, lat);
        issueRequest(makeReq(l2CachePkg::opLoad, l2CachePkg::sizeWord, 32'h034, '0), resp, lat);
        issueRequest(makeReq(l2CachePkg::opLoad, l2CachePkg::sizeWord, 32'h054, '0), resp, lat);
        checkBit("cpuResp.wroteBack", 1'b1, resp.wroteBack);
        issueRequest(makeReq(l2CachePkg::opLoad, l2CachePkg::sizeWord, 32'h014, '0), resp, lat);
        finishTest("dirty eviction", errBefore);

        errBefore = errorCount;                             // Set 6, loads only
        issueRequest(makeReq(l2CachePkg::opLoad, l2CachePkg::sizeWord, 32'h018, '0), resp, lat);
        issueRequest(makeReq(l2CachePkg::opLoad, l2CachePkg::sizeWord, 32'h038, '0), resp, lat);
        issueRequest(makeReq(l2CachePkg::opLoad, l2CachePkg::sizeWord, 32'h058, '0), resp, lat);
        checkBit("cpuResp.wroteBack", 1'b0, resp.wroteBack);
        finishTest("clean eviction", errBefore);

        errBefore = errorCount;
        for (int i = 0; i < 300; i++) begin
            r = nextRand();
            case (r % 3)
                0: begin
                    sz  = l2CachePkg::sizeByte;
                    off = r[9:8];
                end
                1: begin
                    sz  = l2CachePkg::sizeHalf;
                    off = {r[8], 1'b0};                     // Aligned halves only
                end
                default: begin
                    sz  = l2CachePkg::sizeWord;
                    off = 2'b00;
                end
            endcase
            // Four tags over all sets
            issueRequest(makeReq(l2CachePkg::memOpT'(r[16]), sz,
                                 {25'd0, r[12:11], r[15:13], off}, nextRand()), resp, lat);
        end
        finishTest("random run", errBefore);

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: verilog/l2CacheCtrl.sv
`timescale 1ns/10ps

module l2CacheCtrl (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             cpuReq,
    input  l2CachePkg::cpuReqT               cpuReqData,
    output logic                             cpuAck,
    output l2CachePkg::cpuRespT              cpuResp,
    output logic                             lookupEn,     // Register hit / victim
    output logic                             storeEn,      // Merge store into line
    output logic                             touchEn,      // LRU update on load hit
    output logic                             fillEn,       // Write memory word to victim
    input  logic                             hit,
    input  logic                             victimDirty,
    input  logic [l2CachePkg::WORD_BITS-1:0] victimAddr,
    input  logic [l2CachePkg::WORD_BITS-1:0] victimData,
    input  logic [l2CachePkg::WORD_BITS-1:0] lineData,
    output logic                             timerStart,
    input  logic                             timerDone,
    output logic                             memWe,
    output logic                             memRead,
    output logic [l2CachePkg::WORD_BITS-1:0] memAddr,
    output logic [l2CachePkg::WORD_BITS-1:0] memWdata
);

    l2CachePkg::ctrlStateT state;
    l2CachePkg::ctrlStateT stateNext;
    l2CachePkg::cpuReqT    reqQ;                            // Request latched on accept
    logic                  ackQ;
    logic                  wroteBackQ;                      // Set once victim is written
    logic                  isStore;

    assign isStore  = (reqQ.op == l2CachePkg::opStore);
    assign cpuAck   = ackQ;
    assign memWdata = victimData;                           // Only writes are evictions
    assign cpuResp  = '{rdata: lineData, hit: hit, wroteBack: wroteBackQ};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state      <= l2CachePkg::stIdle;
            ackQ       <= 1'b0;
            wroteBackQ <= 1'b0;
        end else begin
            state <= stateNext;
            if (state == l2CachePkg::stIdle && cpuReq) begin
                wroteBackQ <= 1'b0;                         // New transaction
            end
            if (state == l2CachePkg::stWriteBack && timerDone) begin
                wroteBackQ <= 1'b1;
            end
            if (state == l2CachePkg::stRespond) begin
                ackQ <= 1'b1;                               // Response is ready
            end
            if (state == l2CachePkg::stRelease && !cpuReq) begin
                ackQ <= 1'b0;                               // Closes four-phase cycle
            end
        end
    end

    // Payload copy, no reset needed
    always_ff @(posedge clk) begin
        if (state == l2CachePkg::stIdle && cpuReq) begin
            reqQ <= cpuReqData;
        end
    end

    always_comb begin
        stateNext  = state;
        lookupEn   = 1'b0;
        storeEn    = 1'b0;
        touchEn    = 1'b0;
        fillEn     = 1'b0;
        timerStart = 1'b0;
        memWe      = 1'b0;
        memRead    = 1'b0;
        memAddr    = reqQ.addr;                             // Fill address by default
        case (state)
            l2CachePkg::stIdle: begin
                if (cpuReq) begin
                    lookupEn  = 1'b1;                       // Array sees cpuReqData directly
                    stateNext = l2CachePkg::stLookup;
                end
            end
            l2CachePkg::stLookup: begin
                if (hit) begin
                    stateNext = l2CachePkg::stRespond;
                end else if (victimDirty) begin
                    timerStart = 1'b1;
                    memWe      = 1'b1;                      // Evict before refill
                    memAddr    = victimAddr;
                    stateNext  = l2CachePkg::stWriteBack;
                end else begin
                    timerStart = 1'b1;
                    memRead    = 1'b1;
                    stateNext  = l2CachePkg::stFill;
                end
            end
            l2CachePkg::stWriteBack: begin
                if (timerDone) begin
                    timerStart = 1'b1;                      // Back to back with fill
                    memRead    = 1'b1;
                    stateNext  = l2CachePkg::stFill;
                end
            end
            l2CachePkg::stFill: begin
                if (timerDone) begin
                    fillEn    = 1'b1;                       // memRdata valid by now
                    stateNext = l2CachePkg::stRespond;
                end
            end
            l2CachePkg::stRespond: begin
                storeEn   = isStore;                        // Also after a fill
                touchEn   = !isStore && hit;
                stateNext = l2CachePkg::stRelease;
            end
            l2CachePkg::stRelease: begin
                if (!cpuReq) begin
                    stateNext = l2CachePkg::stIdle;
                end
            end
            default: stateNext = l2CachePkg::stIdle;
        endcase
    end

endmodule

// File: verilog/l2CachePkg.sv
package l2CachePkg;

    localparam int WORD_BITS = 32;                 // Data, address and tag base width

    // CPU operation kind
    typedef enum logic {
        opLoad  = 1'b0,
        opStore = 1'b1
    } memOpT;

    // Access size, RISC-V funct3 encoding
    typedef enum logic [2:0] {
        sizeByte = 3'b000,                         // lb / sb
        sizeHalf = 3'b001,                         // lh / sh
        sizeWord = 3'b010                          // lw / sw
    } accessSizeT;

    // One CPU request, held stable by the client during the handshake
    typedef struct packed {
        memOpT                 op;                 // Load or store
        accessSizeT            size;               // Byte lanes touched
        logic [WORD_BITS-1:0]  addr;               // Byte address
        logic [WORD_BITS-1:0]  wdata;              // Store data, low lanes first
    } cpuReqT;

    // Response valid while cpuAck is high
    typedef struct packed {
        logic [WORD_BITS-1:0]  rdata;              // Line word after the access
        logic                  hit;                // Found in cache
        logic                  wroteBack;          // Dirty victim went to memory
    } cpuRespT;

    // Controller sequence
    typedef enum logic [2:0] {
        stIdle,                                    // Waiting for cpuReq
        stLookup,                                  // Tag results examined
        stWriteBack,                               // Dirty victim to memory
        stFill,                                    // Line read from memory
        stRespond,                                 // Store merge / LRU touch
        stRelease                                  // cpuAck held until cpuReq drops
    } ctrlStateT;

endpackage

// File: verilog/l2CacheTop.sv
`timescale 1ns/10ps

module l2CacheTop #(
    parameter int SET_BITS      = 3,                        // 8 sets
    parameter int MEM_LATENCY   = 4,                        // Cycles per memory access
    parameter int MEM_WORD_BITS = 10                        // 1024 words
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                cpuReq,
    input  l2CachePkg::cpuReqT  cpuReqData,
    output logic                cpuAck,
    output l2CachePkg::cpuRespT cpuResp
);

    localparam int WB = l2CachePkg::WORD_BITS;

    logic          lookupEn;
    logic          storeEn;
    logic          touchEn;
    logic          fillEn;
    logic          hit;
    logic          victimDirty;
    logic [WB-1:0] victimAddr;
    logic [WB-1:0] victimData;
    logic [WB-1:0] lineData;
    logic          timerStart;
    logic          timerDone;
    logic          memWe;
    logic          memRead;
    logic [WB-1:0] memAddr;
    logic [WB-1:0] memWdata;
    logic [WB-1:0] memRdata;                                // Fill data straight to array

    l2CacheCtrl ctrl_i (
        .clk        (clk),
        .rstN       (rstN),
        .cpuReq     (cpuReq),
        .cpuReqData (cpuReqData),
        .cpuAck     (cpuAck),
        .cpuResp    (cpuResp),
        .lookupEn   (lookupEn),
        .storeEn    (storeEn),
        .touchEn    (touchEn),
        .fillEn     (fillEn),
        .hit        (hit),
        .victimDirty(victimDirty),
        .victimAddr (victimAddr),
        .victimData (victimData),
        .lineData   (lineData),
        .timerStart (timerStart),
        .timerDone  (timerDone),
        .memWe      (memWe),
        .memRead    (memRead),
        .memAddr    (memAddr),
        .memWdata   (memWdata)
    );

    memLatencyTimer #(.MEM_LATENCY(MEM_LATENCY)) timer_i (
        .clk  (clk),
        .rstN (rstN),
        .start(timerStart),
        .done (timerDone)
    );

    // Array indexes with the client's held request
    l2SetArray #(.SET_BITS(SET_BITS)) setArray_i (
        .clk        (clk),
        .rstN       (rstN),
        .req        (cpuReqData),
        .lookupEn   (lookupEn),
        .storeEn    (storeEn),
        .touchEn    (touchEn),
        .fillEn     (fillEn),
        .fillData   (memRdata),
        .hit        (hit),
        .victimDirty(victimDirty),
        .victimAddr (victimAddr),
        .victimData (victimData),
        .lineData   (lineData)
    );

    mainMemory #(.MEM_WORD_BITS(MEM_WORD_BITS)) mem_i (
        .clk  (clk),
        .we   (memWe),
        .re   (memRead),
        .addr (memAddr),
        .wdata(memWdata),
        .rdata(memRdata)
    );

endmodule

// File: verilog/l2SetArray.sv
`timescale 1ns/10ps

module l2SetArray #(
    parameter int SET_BITS = 3
) (
    input  logic                             clk,
    input  logic                             rstN,
    input  l2CachePkg::cpuReqT               req,
    input  logic                             lookupEn,
    input  logic                             storeEn,
    input  logic                             touchEn,
    input  logic                             fillEn,
    input  logic [l2CachePkg::WORD_BITS-1:0] fillData,
    output logic                             hit,
    output logic                             victimDirty,
    output logic [l2CachePkg::WORD_BITS-1:0] victimAddr,
    output logic [l2CachePkg::WORD_BITS-1:0] victimData,
    output logic [l2CachePkg::WORD_BITS-1:0] lineData
);

    localparam int WB       = l2CachePkg::WORD_BITS;
    localparam int TAG_BITS = 30 - SET_BITS;                // Word lines, 2 offset bits
    localparam int SETS     = 1 << SET_BITS;

    logic [TAG_BITS-1:0] tagMem  [2][SETS];
    logic [WB-1:0]       dataMem [2][SETS];
    logic                validQ  [2][SETS];
    logic                dirtyQ  [2][SETS];
    logic                lruQ    [SETS];                    // Way to evict next

    logic [SET_BITS-1:0] setIdx;
    logic [TAG_BITS-1:0] reqTag;
    logic [1:0]          wayHit;
    logic                lookupWay;
    logic                selWayQ;                           // Hit way or victim way
    logic [1:0]          offset;
    logic [3:0]          laneMask;
    logic [WB-1:0]       shiftedData;
    logic [WB-1:0]       mergedData;

    assign setIdx   = req.addr[SET_BITS+1:2];
    assign reqTag   = req.addr[WB-1:SET_BITS+2];
    assign offset   = req.addr[1:0];
    assign lineData = dataMem[selWayQ][setIdx];             // Live contents, not registered

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayHit[w] = validQ[w][setIdx] && (tagMem[w][setIdx] == reqTag);
        end
        lookupWay = (wayHit != 2'b00) ? wayHit[1] : lruQ[setIdx];
    end

    // Byte-lane merge for sb / sh / sw
    always_comb begin
        case (req.size)
            l2CachePkg::sizeByte: laneMask = 4'b0001 << offset;
            l2CachePkg::sizeHalf: laneMask = 4'b0011 << offset;
            l2CachePkg::sizeWord: laneMask = 4'b1111;
            default:              laneMask = 4'b0000;      // Reserved funct3, no write
        endcase
        shiftedData = req.wdata << {offset, 3'b000};
        for (int b = 0; b < 4; b++) begin
            mergedData[8*b +: 8] = laneMask[b] ? shiftedData[8*b +: 8] : lineData[8*b +: 8];
        end
    end

    // Control bits and lookup results
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int s = 0; s < SETS; s++) begin
                validQ[0][s] <= 1'b0;
                validQ[1][s] <= 1'b0;
                dirtyQ[0][s] <= 1'b0;
                dirtyQ[1][s] <= 1'b0;
                lruQ[s]      <= 1'b0;                       // Way 0 first
            end
            hit         <= 1'b0;
            victimDirty <= 1'b0;
            selWayQ     <= 1'b0;
        end else begin
            if (lookupEn) begin
                hit         <= (wayHit != 2'b00);
                selWayQ     <= lookupWay;
                victimDirty <= (wayHit == 2'b00) && validQ[lookupWay][setIdx]
                               && dirtyQ[lookupWay][setIdx];
            end
            if (fillEn) begin
                validQ[selWayQ][setIdx] <= 1'b1;
                dirtyQ[selWayQ][setIdx] <= 1'b0;            // Clean copy of memory
            end
            if (storeEn) begin
                dirtyQ[selWayQ][setIdx] <= 1'b1;
            end
            if (fillEn || storeEn || touchEn) begin
                lruQ[setIdx] <= ~selWayQ;                   // Other way now oldest
            end
        end
    end

    // Storage and victim payload
    always_ff @(posedge clk) begin
        if (lookupEn) begin
            victimAddr <= {tagMem[lookupWay][setIdx], setIdx, 2'b00};
            victimData <= dataMem[lookupWay][setIdx];
        end
        if (fillEn) begin
            tagMem[selWayQ][setIdx]  <= reqTag;
            dataMem[selWayQ][setIdx] <= fillData;
        end else if (storeEn) begin
            dataMem[selWayQ][setIdx] <= mergedData;
        end
    end

endmodule

// File: verilog/mainMemory.sv
`timescale 1ns/10ps

module mainMemory #(
    parameter int MEM_WORD_BITS = 10
) (
    input  logic                             clk,
    input  logic                             we,            // Write strobe
    input  logic                             re,            // Read strobe
    input  logic [l2CachePkg::WORD_BITS-1:0] addr,          // Byte address that wraps
    input  logic [l2CachePkg::WORD_BITS-1:0] wdata,
    output logic [l2CachePkg::WORD_BITS-1:0] rdata          // Held until next re
);

    localparam int DEPTH = 1 << MEM_WORD_BITS;

    logic [l2CachePkg::WORD_BITS-1:0] mem [DEPTH];
    logic [MEM_WORD_BITS-1:0]         wordIdx;

    assign wordIdx = addr[MEM_WORD_BITS+1:2];               // Upper bits ignored

    // Known pattern so a cold miss is predictable
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'hA5A5_0000 ^ 32'(i);
        end
    end

    always @(posedge clk) begin
        if (we) begin
            mem[wordIdx] <= wdata;
        end
        if (re) begin
            rdata <= mem[wordIdx];                          // Old word on a same-cycle write
        end
    end

endmodule

// File: verilog/memLatencyTimer.sv
`timescale 1ns/10ps

module memLatencyTimer #(
    parameter int MEM_LATENCY = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic start,                                     // Load MEM_LATENCY
    output logic done                                       // High at zero count
);

    // At least one bit, even for zero latency
    localparam int CNT_BITS = (MEM_LATENCY > 0) ? $clog2(MEM_LATENCY + 1) : 1;

    logic [CNT_BITS-1:0] count;
    logic                armedQ;                            // Low until first start

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count  <= '0;
            armedQ <= 1'b0;
        end else if (start) begin
            count  <= CNT_BITS'(MEM_LATENCY);
            armedQ <= 1'b1;
        end else if (count != '0) begin
            count <= count - 1'b1;                          // Holds at zero
        end
    end

    assign done = armedQ && (count == '0);

endmodule
